/* data_mem_top.f */
+incdir+verilog
verilog/axil_pkg.sv
verilog/data_sram.sv
verilog/axil_data_sram_wrap.sv
verilog/lsu_axil_master.sv
verilog/data_mem_top.sv
testbench/tb_clk_gen.sv
testbench/tb_data_mem_top.sv

/* testbench/tb_clk_gen.sv */
// Testbench clock and reset source, 20 ns clock with reset held low for 16 cycles
`timescale 1ns/1ps

module tb_clk_gen (
  output logic o_aclk,
  output logic o_rst_n
);

  localparam int HALF_PERIOD_NS = 10;
  localparam int RESET_CYCLES   = 16;

  initial begin
    o_aclk = 1'b0;
    forever #(HALF_PERIOD_NS) o_aclk = ~o_aclk;
  end

  // Release on a falling edge, away from the DUT's sampling edge
  initial begin
    o_rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_aclk);
    @(negedge o_aclk);
    o_rst_n <= 1'b1;
  end

endmodule

/* testbench/tb_data_mem_top.sv */
// Directed and random testbench for the data memory path, run as the simulation top
`timescale 1ns/1ps
`include "axil_defines.svh"

module tb_data_mem_top
  import axil_pkg::*;
();

  localparam addr_t       BASE      = `DMEM_BASE_ADDR;
  localparam int unsigned WIN_BYTES = `DMEM_DEPTH_WORDS * `AXIL_STRB_WIDTH;
  localparam int          TIMEOUT   = 200;

  logic     aclk;
  logic     rst_n;
  mem_req_t req;
  logic     req_valid;
  logic     req_ready;
  mem_rsp_t rsp;
  logic     rsp_valid;
  logic     rsp_ready;

  // Reference memory, one entry per SRAM word
  data_t ref_mem [word_idx_t];
  int    max_stall;

  tb_clk_gen u_clk_gen (
    .o_aclk  (aclk),
    .o_rst_n (rst_n)
  );

  data_mem_top u_dut (
    .i_aclk      (aclk),
    .i_rst_n     (rst_n),
    .i_req       (req),
    .i_req_valid (req_valid),
    .o_req_ready (req_ready),
    .o_rsp       (rsp),
    .o_rsp_valid (rsp_valid),
    .i_rsp_ready (rsp_ready)
  );

  // --------------------
  // Model helpers
  // --------------------
  function automatic logic in_window(addr_t addr);
    return (addr >= BASE) && ((addr - BASE) < WIN_BYTES);
  endfunction

  function automatic word_idx_t index_of(addr_t addr);
    return word_idx_t'((addr - BASE) / `AXIL_STRB_WIDTH);
  endfunction

  function automatic data_t merge_bytes(data_t old_word, data_t new_word, strb_t strb);
    data_t merged;
    merged = old_word;
    for (int b = 0; b < $bits(strb_t); b++) begin
      if (strb[b]) merged[8*b +: 8] = new_word[8*b +: 8];
    end
    return merged;
  endfunction

  // Distinct per word, built from the whole byte address
  function automatic data_t fill_pattern(addr_t addr);
    return {addr ^ 32'hA5A5_0F0F, ~addr};
  endfunction

  // --------------------
  // Failure and compare
  // --------------------
  task automatic fail_run(string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic check_data(string what, data_t exp, data_t got);
    if (got !== exp)
      fail_run($sformatf("Mismatch at %0d ns: %s expected %h got %h", $time, what, exp, got));
  endtask

  task automatic check_resp(string what, resp_t exp, resp_t got);
    if (got !== exp)
      fail_run($sformatf("Mismatch at %0d ns: %s expected %0d got %0d", $time, what, exp, got));
  endtask

  task automatic check_flag(string what, logic exp, logic got);
    if (got !== exp)
      fail_run($sformatf("Mismatch at %0d ns: %s expected %b got %b", $time, what, exp, got));
  endtask

  // --------------------
  // Request side driver
  // --------------------
  task automatic wait_reset_release();
    int cycles;
    cycles = 0;
    @(negedge aclk);
    while (!rst_n) begin
      cycles++;
      if (cycles >= TIMEOUT) fail_run("Reset was never released");
      @(negedge aclk);
    end
  endtask

  task automatic send_request(mem_req_t r);
    int cycles;
    cycles = 0;
    @(negedge aclk);
    while (!req_ready) begin
      cycles++;
      if (cycles >= TIMEOUT) fail_run("Timed out waiting for o_req_ready");
      @(negedge aclk);
    end
    // Ready is high here, so the transfer happens on the next rising edge
    req       = r;
    req_valid = 1'b1;
    @(negedge aclk);
    req_valid = 1'b0;
    req       = '0;
  endtask

  task automatic collect_response(output mem_rsp_t got);
    int       cycles;
    int       stall;
    mem_rsp_t held;
    cycles = 0;
    while (!rsp_valid) begin
      cycles++;
      if (cycles >= TIMEOUT) fail_run("Timed out waiting for o_rsp_valid");
      @(negedge aclk);
    end
    held  = rsp;
    stall = $urandom_range(max_stall, 0);
    // Completion must stay put while the LSU is not ready
    repeat (stall) begin
      @(negedge aclk);
      check_flag("o_rsp_valid under back-pressure", 1'b1, rsp_valid);
      check_data("held rdata", held.rdata, rsp.rdata);
      check_resp("held resp", held.resp, rsp.resp);
    end
    got       = rsp;
    rsp_ready = 1'b1;
    @(negedge aclk);
    rsp_ready = 1'b0;
    check_flag("o_rsp_valid after acceptance", 1'b0, rsp_valid);
  endtask

  task automatic do_write(addr_t addr, data_t data, strb_t strb);
    mem_req_t r;
    mem_rsp_t got;
    r = '{is_write: 1'b1, addr: addr, wdata: data, wstrb: strb};
    send_request(r);
    collect_response(got);
    if (in_window(addr)) begin
      check_resp($sformatf("write resp @%h", addr), RESP_OKAY, got.resp);
      ref_mem[index_of(addr)] = merge_bytes(ref_mem[index_of(addr)], data, strb);
    end else begin
      check_resp($sformatf("write resp @%h", addr), RESP_SLVERR, got.resp);
    end
  endtask

  task automatic do_read(addr_t addr);
    mem_req_t r;
    mem_rsp_t got;
    r = '{is_write: 1'b0, addr: addr, wdata: '0, wstrb: '0};
    send_request(r);
    collect_response(got);
    if (in_window(addr)) begin
      check_resp($sformatf("read resp @%h", addr), RESP_OKAY, got.resp);
      check_data($sformatf("read data @%h", addr), ref_mem[index_of(addr)], got.rdata);
    end else begin
      check_resp($sformatf("read resp @%h", addr), RESP_SLVERR, got.resp);
      check_data($sformatf("read data @%h", addr), '0, got.rdata);
    end
  endtask

  // --------------------
  // Tests
  // --------------------
  task automatic test_reset_state();
    check_flag("o_req_ready after reset", 1'b1, req_ready);
    check_flag("o_rsp_valid after reset", 1'b0, rsp_valid);
  endtask

  // Every word gets a known value so later reads never hit undefined storage
  task automatic init_memory();
    addr_t addr;
    for (int i = 0; i < `DMEM_DEPTH_WORDS; i++) begin
      addr = BASE + addr_t'(i * `AXIL_STRB_WIDTH);
      ref_mem[index_of(addr)] = '0;
      do_write(addr, fill_pattern(addr), '1);
    end
  endtask

  task automatic test_full_word();
    int unsigned idx_list [7] = '{0, 511, 1, 100, 255, 256, 400};
    addr_t addr;
    foreach (idx_list[i]) begin
      addr = BASE + addr_t'(idx_list[i] * `AXIL_STRB_WIDTH);
      do_write(addr, {$urandom, $urandom}, '1);
      do_read(addr);
    end
    // Offset bits below the word are ignored
    do_read(BASE + 32'd803);
  endtask

  task automatic test_partial_strobe();
    strb_t strb_list [6] = '{8'h01, 8'h80, 8'h0F, 8'hA5, 8'h3C, 8'h00};
    addr_t addr;
    addr = BASE + 32'd296;
    foreach (strb_list[i]) begin
      do_write(addr, {$urandom, $urandom}, strb_list[i]);
      do_read(addr);
    end
  endtask

  task automatic test_out_of_range();
    // Just past the window aliases word 0
    do_write(BASE + WIN_BYTES, {$urandom, $urandom}, '1);
    do_read(BASE);
    // Just below the window aliases the last word
    do_write(BASE - 32'd8, {$urandom, $urandom}, '1);
    do_read(BASE + WIN_BYTES - 32'd8);
    do_read(BASE + WIN_BYTES);
    do_read(32'h0000_1000);
  endtask

  task automatic test_random();
    addr_t addr;
    max_stall = 5;
    repeat (200) begin
      if ($urandom_range(9, 0) != 0) addr = BASE + addr_t'($urandom_range(WIN_BYTES - 1, 0));
      else addr = addr_t'($urandom);
      if ($urandom_range(1, 0) == 1) do_write(addr, {$urandom, $urandom}, strb_t'($urandom));
      else do_read(addr);
    end
    max_stall = 0;
  endtask

  initial begin
    void'($urandom(34441));
    req       = '0;
    req_valid = 1'b0;
    rsp_ready = 1'b0;
    max_stall = 0;

    wait_reset_release();
    test_reset_state();
    init_memory();
    test_full_word();
    test_partial_strobe();
    test_out_of_range();
    test_random();

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

/* verilog/axil_data_sram_wrap.sv */
// AXI-lite slave around the data SRAM with separate read and write FSMs, instantiated by the top level
`timescale 1ns/1ps
`include "axil_defines.svh"

module axil_data_sram_wrap
  import axil_pkg::*;
(
  input  logic     i_aclk,
  input  logic     i_rst_n,

  // Write channels
  input  axil_aw_t i_aw,
  input  logic     i_awvalid,
  output logic     o_awready,
  input  axil_w_t  i_w,
  input  logic     i_wvalid,
  output logic     o_wready,
  output axil_b_t  o_b,
  output logic     o_bvalid,
  input  logic     i_bready,

  // Read channels
  input  axil_ar_t i_ar,
  input  logic     i_arvalid,
  output logic     o_arready,
  output axil_r_t  o_r,
  output logic     o_rvalid,
  input  logic     i_rready
);

  // Byte offset bits below the word index
  localparam int unsigned OFFSET_BITS = $clog2(`AXIL_STRB_WIDTH);
  localparam addr_t       WIN_BASE    = `DMEM_BASE_ADDR;
  localparam addr_t       WIN_BYTES   = `DMEM_DEPTH_WORDS * `AXIL_STRB_WIDTH;

  wr_state_e wr_state_q;
  rd_state_e rd_state_q;

  word_idx_t wr_idx_q;
  logic      wr_hit_q;
  word_idx_t rd_idx_q;
  logic      rd_hit_q;

  logic      aw_fire;
  logic      w_fire;
  logic      b_fire;
  logic      ar_fire;
  logic      r_fire;

  logic      sram_wr_en;
  logic      sram_rd_en;
  logic      rd_gnt;
  word_idx_t sram_idx;
  data_t     sram_rdata;

  function automatic logic in_window(addr_t addr);
    addr_t offset;
    offset = addr - WIN_BASE;
    return (addr >= WIN_BASE) && (offset < WIN_BYTES);
  endfunction

  function automatic word_idx_t word_index(addr_t addr);
    return addr[OFFSET_BITS +: $bits(word_idx_t)];
  endfunction

  assign aw_fire = i_awvalid & o_awready;
  assign w_fire  = i_wvalid & o_wready;
  assign b_fire  = o_bvalid & i_bready;
  assign ar_fire = i_arvalid & o_arready;
  assign r_fire  = o_rvalid & i_rready;

  // --------------------
  // Write path
  // --------------------
  assign o_awready = (wr_state_q == WS_IDLE);
  assign o_wready  = (wr_state_q == WS_DATA);
  assign o_bvalid  = (wr_state_q == WS_RESP);
  assign o_b.resp  = wr_hit_q ? RESP_OKAY : RESP_SLVERR;

  // Out-of-window writes are dropped
  assign sram_wr_en = w_fire & wr_hit_q;

  always_ff @(posedge i_aclk) begin
    if (!i_rst_n) begin
      wr_state_q <= WS_IDLE;
    end else begin
      case (wr_state_q)
        WS_IDLE: if (aw_fire) wr_state_q <= WS_DATA;
        WS_DATA: if (w_fire) wr_state_q <= WS_RESP;
        WS_RESP: if (b_fire) wr_state_q <= WS_IDLE;
        default: wr_state_q <= WS_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_aclk) begin
    if (aw_fire) begin
      wr_idx_q <= word_index(i_aw.addr);
      wr_hit_q <= in_window(i_aw.addr);
    end
  end

  // --------------------
  // Read path
  // --------------------
  assign o_arready = (rd_state_q == RS_IDLE);
  assign o_rvalid  = (rd_state_q == RS_DATA);

  // A write in the same cycle owns the single port
  assign rd_gnt     = (rd_state_q == RS_READ) & ~sram_wr_en;
  assign sram_rd_en = rd_gnt & rd_hit_q;

  // SRAM output register holds until the next granted read
  assign o_r.data = rd_hit_q ? sram_rdata : '0;
  assign o_r.resp = rd_hit_q ? RESP_OKAY : RESP_SLVERR;

  always_ff @(posedge i_aclk) begin
    if (!i_rst_n) begin
      rd_state_q <= RS_IDLE;
    end else begin
      case (rd_state_q)
        RS_IDLE: if (ar_fire) rd_state_q <= RS_READ;
        RS_READ: if (rd_gnt) rd_state_q <= RS_DATA;
        RS_DATA: if (r_fire) rd_state_q <= RS_IDLE;
        default: rd_state_q <= RS_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_aclk) begin
    if (ar_fire) begin
      rd_idx_q <= word_index(i_ar.addr);
      rd_hit_q <= in_window(i_ar.addr);
    end
  end

  // --------------------
  // Storage
  // --------------------
  assign sram_idx = sram_wr_en ? wr_idx_q : rd_idx_q;

  data_sram u_data_sram (
    .i_aclk  (i_aclk),
    .i_rd_en (sram_rd_en),
    .i_wr_en (sram_wr_en),
    .i_idx   (sram_idx),
    .i_wdata (i_w.data),
    .i_wstrb (i_w.strb),
    .o_rdata (sram_rdata)
  );

endmodule

/* verilog/axil_defines.svh */
// Bus widths and data memory window, included by the package and by RTL that needs them
`ifndef AXIL_DEFINES_SVH
`define AXIL_DEFINES_SVH

// --------------------
// AXI-lite bus
// --------------------
`define AXIL_DATA_WIDTH 64
`define AXIL_ADDR_WIDTH 32
// One strobe bit per byte lane
`define AXIL_STRB_WIDTH (`AXIL_DATA_WIDTH / 8)

// --------------------
// Data memory window
// --------------------
// 4 KiB of 64-bit words
`define DMEM_DEPTH_WORDS 512
`define DMEM_BASE_ADDR 32'h8000_0000

`endif

/* verilog/axil_pkg.sv */
// Shared types for the data memory path, imported by the bridge, the slave wrapper and the SRAM
`include "axil_defines.svh"

package axil_pkg;

  // Width typedefs
  typedef logic [`AXIL_ADDR_WIDTH-1:0]          addr_t;
  typedef logic [`AXIL_DATA_WIDTH-1:0]          data_t;
  typedef logic [`AXIL_STRB_WIDTH-1:0]          strb_t;
  typedef logic [1:0]                           resp_t;
  typedef logic [$clog2(`DMEM_DEPTH_WORDS)-1:0] word_idx_t;

  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  // --------------------
  // AXI-lite channel payloads
  // --------------------
  typedef struct packed {addr_t addr;} axil_aw_t;
  typedef struct packed {data_t data; strb_t strb;} axil_w_t;
  typedef struct packed {resp_t resp;} axil_b_t;
  typedef struct packed {addr_t addr;} axil_ar_t;
  typedef struct packed {data_t data; resp_t resp;} axil_r_t;

  // Load/store request and its completion
  typedef struct packed {
    logic  is_write;
    addr_t addr;
    data_t wdata;
    strb_t wstrb;
  } mem_req_t;

  typedef struct packed {
    data_t rdata;
    resp_t resp;
  } mem_rsp_t;

  // --------------------
  // State machines
  // --------------------
  typedef enum logic [2:0] {IDLE, WR_ADDR, WR_DATA, WR_RESP, RD_ADDR, RD_DATA} mst_state_e;
  typedef enum logic [1:0] {WS_IDLE, WS_DATA, WS_RESP} wr_state_e;
  typedef enum logic [1:0] {RS_IDLE, RS_READ, RS_DATA} rd_state_e;

endpackage

/* verilog/data_mem_top.sv */
// Data memory subsystem top level joining the LSU bridge and the SRAM slave wrapper
`timescale 1ns/1ps

module data_mem_top
  import axil_pkg::*;
(
  input  logic     i_aclk,
  input  logic     i_rst_n,

  input  mem_req_t i_req,
  input  logic     i_req_valid,
  output logic     o_req_ready,

  output mem_rsp_t o_rsp,
  output logic     o_rsp_valid,
  input  logic     i_rsp_ready
);

  // --------------------
  // AXI-lite channels
  // --------------------
  axil_aw_t aw;
  logic     awvalid;
  logic     awready;
  axil_w_t  w;
  logic     wvalid;
  logic     wready;
  axil_b_t  b;
  logic     bvalid;
  logic     bready;
  axil_ar_t ar;
  logic     arvalid;
  logic     arready;
  axil_r_t  r;
  logic     rvalid;
  logic     rready;

  lsu_axil_master u_lsu_axil_master (
    .i_aclk      (i_aclk),
    .i_rst_n     (i_rst_n),
    .i_req       (i_req),
    .i_req_valid (i_req_valid),
    .o_req_ready (o_req_ready),
    .o_rsp       (o_rsp),
    .o_rsp_valid (o_rsp_valid),
    .i_rsp_ready (i_rsp_ready),
    .o_aw        (aw),
    .o_awvalid   (awvalid),
    .i_awready   (awready),
    .o_w         (w),
    .o_wvalid    (wvalid),
    .i_wready    (wready),
    .i_b         (b),
    .i_bvalid    (bvalid),
    .o_bready    (bready),
    .o_ar        (ar),
    .o_arvalid   (arvalid),
    .i_arready   (arready),
    .i_r         (r),
    .i_rvalid    (rvalid),
    .o_rready    (rready)
  );

  axil_data_sram_wrap u_axil_data_sram_wrap (
    .i_aclk    (i_aclk),
    .i_rst_n   (i_rst_n),
    .i_aw      (aw),
    .i_awvalid (awvalid),
    .o_awready (awready),
    .i_w       (w),
    .i_wvalid  (wvalid),
    .o_wready  (wready),
    .o_b       (b),
    .o_bvalid  (bvalid),
    .i_bready  (bready),
    .i_ar      (ar),
    .i_arvalid (arvalid),
    .o_arready (arready),
    .o_r       (r),
    .o_rvalid  (rvalid),
    .i_rready  (rready)
  );

endmodule

/* verilog/data_sram.sv */
// Single-port data SRAM with byte enables and a registered read, used under the AXI-lite wrapper
`timescale 1ns/1ps
`include "axil_defines.svh"

module data_sram
  import axil_pkg::*;
(
  input  logic      i_aclk,
  input  logic      i_rd_en,
  input  logic      i_wr_en,
  input  word_idx_t i_idx,
  input  data_t     i_wdata,
  input  strb_t     i_wstrb,
  output data_t     o_rdata
);

  localparam int unsigned NUM_BYTES = $bits(strb_t);

  // Storage array, contents undefined until written
  data_t mem [`DMEM_DEPTH_WORDS];

  // --------------------
  // Byte-masked write
  // --------------------
  always_ff @(posedge i_aclk) begin
    if (i_wr_en) begin
      for (int b = 0; b < NUM_BYTES; b++) begin
        if (i_wstrb[b]) begin
          mem[i_idx][8*b +: 8] <= i_wdata[8*b +: 8];
        end
      end
    end
  end

  // --------------------
  // Registered read
  // --------------------
  // Output holds its value between read enables
  always_ff @(posedge i_aclk) begin
    if (i_rd_en) begin
      o_rdata <= mem[i_idx];
    end
  end

endmodule

/* verilog/lsu_axil_master.sv */
// Load/store request to AXI-lite master bridge, one transaction in flight, used by the top level
`timescale 1ns/1ps

module lsu_axil_master
  import axil_pkg::*;
(
  input  logic     i_aclk,
  input  logic     i_rst_n,

  // Load/store request
  input  mem_req_t i_req,
  input  logic     i_req_valid,
  output logic     o_req_ready,

  // Completion
  output mem_rsp_t o_rsp,
  output logic     o_rsp_valid,
  input  logic     i_rsp_ready,

  // Write address
  output axil_aw_t o_aw,
  output logic     o_awvalid,
  input  logic     i_awready,

  // Write data
  output axil_w_t  o_w,
  output logic     o_wvalid,
  input  logic     i_wready,

  // Write response
  input  axil_b_t  i_b,
  input  logic     i_bvalid,
  output logic     o_bready,

  // Read address
  output axil_ar_t o_ar,
  output logic     o_arvalid,
  input  logic     i_arready,

  // Read data
  input  axil_r_t  i_r,
  input  logic     i_rvalid,
  output logic     o_rready
);

  mst_state_e state_q;
  mem_req_t   req_q;
  mem_rsp_t   rsp_q;
  logic       rsp_valid_q;

  logic req_fire;
  logic rsp_fire;
  logic aw_fire;
  logic w_fire;
  logic b_fire;
  logic ar_fire;
  logic r_fire;

  // --------------------
  // Handshakes
  // --------------------
  assign req_fire = i_req_valid & o_req_ready;
  assign rsp_fire = o_rsp_valid & i_rsp_ready;
  assign aw_fire  = o_awvalid & i_awready;
  assign w_fire   = o_wvalid & i_wready;
  assign b_fire   = i_bvalid & o_bready;
  assign ar_fire  = o_arvalid & i_arready;
  assign r_fire   = i_rvalid & o_rready;

  // New work only once the previous completion has been taken
  assign o_req_ready = (state_q == IDLE) & ~rsp_valid_q;

  // Channel controls come straight from the phase
  assign o_awvalid = (state_q == WR_ADDR);
  assign o_wvalid  = (state_q == WR_DATA);
  assign o_bready  = (state_q == WR_RESP);
  assign o_arvalid = (state_q == RD_ADDR);
  assign o_rready  = (state_q == RD_DATA);

  // Payloads held from the latched request
  assign o_aw.addr = req_q.addr;
  assign o_w.data  = req_q.wdata;
  assign o_w.strb  = req_q.wstrb;
  assign o_ar.addr = req_q.addr;

  assign o_rsp       = rsp_q;
  assign o_rsp_valid = rsp_valid_q;

  // --------------------
  // Phase sequencing
  // --------------------
  always_ff @(posedge i_aclk) begin
    if (!i_rst_n) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE: begin
          if (req_fire) begin
            state_q <= i_req.is_write ? WR_ADDR : RD_ADDR;
          end
        end
        WR_ADDR: begin
          if (aw_fire) begin
            state_q <= WR_DATA;
          end
        end
        WR_DATA: begin
          if (w_fire) begin
            state_q <= WR_RESP;
          end
        end
        WR_RESP: begin
          if (b_fire) begin
            state_q <= IDLE;
          end
        end
        RD_ADDR: begin
          if (ar_fire) begin
            state_q <= RD_DATA;
          end
        end
        RD_DATA: begin
          if (r_fire) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Completion flag, held until the LSU takes it
  always_ff @(posedge i_aclk) begin
    if (!i_rst_n) begin
      rsp_valid_q <= 1'b0;
    end else if (b_fire | r_fire) begin
      rsp_valid_q <= 1'b1;
    end else if (rsp_fire) begin
      rsp_valid_q <= 1'b0;
    end
  end

  // Request and completion payloads
  always_ff @(posedge i_aclk) begin
    if (req_fire) begin
      req_q <= i_req;
    end
    if (b_fire) begin
      rsp_q.rdata <= '0;
      rsp_q.resp  <= i_b.resp;
    end else if (r_fire) begin
      rsp_q.rdata <= i_r.data;
      rsp_q.resp  <= i_r.resp;
    end
  end

endmodule
